//--- Makefile
SIM  := obj_dir/Vpool_tb
SRCS := $(filter-out +incdir+%,$(shell cat project.f))

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS) hdl/pool_defines.svh
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module pool_tb -f project.f -o Vpool_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- dv/pool_tb.sv
// Self-checking testbench for pool_top, compiled from project.f with pool_tb as top module
`default_nettype none
`include "pool_defines.svh"

module pool_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pool_pkg::*;

    localparam int STALL_LIMIT  = 1000;
    localparam int WAIT_LIMIT   = 3000;
    localparam int BLOCK_CYCLES = 32;
    // Serializer and engine each hold one pooled pair, the deserializer one more row
    localparam int BLOCKED_WORDS = (2 * `POOL_SIZE + 1) * `POOL_ROW_WIDTH;
    localparam int IMAGE_PAIRS   = `POOL_ROW_WIDTH / `POOL_SIZE;

    logic  clock_i;
    logic  reset_i;
    word_t in_data_i;
    logic  in_valid_i;
    logic  upstream_stall_o;
    word_t out_data_o;
    logic  out_valid_o;
    logic  downstream_stall_i;

    // Expected output words, oldest first
    word_t model_q [$];
    word_t exp_word = '0;
    logic  exp_avail = 1'b0;
    logic  prev_reset = 1'b0;
    int    run_words = 0;
    int    out_words = 0;
    int    words_in = 0;
    int    expected_total = 0;
    // 0 no stall, 1 random stall, 2 stall held
    int    stall_mode = 0;
    string test_name = "setup";
    int    tests_run = 0;
    int    tests_failed = 0;
    int    reset_errors = 0;
    int    hold_errors = 0;
    int    value_errors = 0;
    int    extra_errors = 0;
    int    run_errors = 0;
    int    flow_errors = 0;

    pool_top DUT (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

    initial begin
        clock_i = 1'b0;
        forever begin
            #2 clock_i = ~clock_i;
        end
    end

    // Sink stall, the coin is drawn on the edge and applied just after it
    initial begin
        int   mode;
        logic coin;
        downstream_stall_i = 1'b0;
        forever begin
            @(posedge clock_i);
            mode = stall_mode;
            coin = ($urandom_range(1) == 1);
            #1;
            downstream_stall_i = (mode == 2) || (mode == 1 && coin);
        end
    end

    // Sample mid cycle what the next edge sees, update bookkeeping after that edge
    always begin
        logic took;
        logic was_reset;
        logic word_in;
        logic stall_seen;
        @(negedge clock_i);
        exp_avail  = (model_q.size() > 0);
        exp_word   = exp_avail ? model_q[0] : '0;
        was_reset  = reset_i;
        took       = !reset_i && out_valid_o && !downstream_stall_i;
        word_in    = in_valid_i && !upstream_stall_o;
        stall_seen = upstream_stall_o;
        @(posedge clock_i);
        #1;
        prev_reset = was_reset;
        if (took) begin
            out_words++;
            if (model_q.size() > 0) begin
                void'(model_q.pop_front());
            end
        end
        if (was_reset || stall_seen) begin
            run_words = 0;
        end else if (word_in) begin
            run_words++;
        end
    end

    reset_quiet_a: assert property (@(posedge clock_i)
        prev_reset |-> (!out_valid_o && !upstream_stall_o))
    else begin
        $display("%s: output valid or input stall active during reset", test_name);
        reset_errors++;
    end

    out_hold_a: assert property (@(posedge clock_i) disable iff (reset_i)
        (out_valid_o && downstream_stall_i) |=> (out_valid_o && $stable(out_data_o)))
    else begin
        $display("%s: output word changed or dropped while the sink stalled", test_name);
        hold_errors++;
    end

    out_extra_a: assert property (@(posedge clock_i) disable iff (reset_i)
        (out_valid_o && !downstream_stall_i) |-> exp_avail)
    else begin
        $display("%s: output word transferred when none was expected", test_name);
        extra_errors++;
    end

    out_value_a: assert property (@(posedge clock_i) disable iff (reset_i)
        (out_valid_o && !downstream_stall_i && exp_avail) |-> (out_data_o == exp_word))
    else begin
        $display("error %s: expected %h, actual %h", test_name, exp_word,
                 $sampled(out_data_o));
        value_errors++;
    end

    in_run_a: assert property (@(posedge clock_i) disable iff (reset_i)
        run_words <= 2 * `POOL_ROW_WIDTH)
    else begin
        $display("%s: input accepted %0d words without raising the stall", test_name, run_words);
        run_errors++;
    end

    function automatic pixel_t max_of_block(input pixel_t a, input pixel_t b,
                                            input pixel_t c, input pixel_t d);
        pixel_t top;
        pixel_t bottom;
        top    = (a > b) ? a : b;
        bottom = (c > d) ? c : d;
        return (top > bottom) ? top : bottom;
    endfunction

    function automatic int error_total();
        return reset_errors + hold_errors + value_errors + extra_errors + run_errors + flow_errors;
    endfunction

    task automatic report_test(input int errors_before);
        tests_run++;
        if (error_total() == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_total() - errors_before);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d tests, %0d failed, %0d errors, %0d words in, %0d words out",
                 tests_run, tests_failed, error_total(), words_in, out_words);
        if (error_total() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_word(input word_t w);
        int waited;
        waited = 0;
        in_data_i  = w;
        in_valid_i = 1'b1;
        while (upstream_stall_o) begin
            @(posedge clock_i);
            #1;
            waited++;
            if (waited > STALL_LIMIT) begin
                $display("timeout in %s: input stayed stalled for %0d cycles", test_name, waited);
                flow_errors++;
                finish_run();
            end
        end
        @(posedge clock_i);
        #1;
        in_valid_i = 1'b0;
        words_in++;
    endtask

    // Two rows of random pixels, expected maxima queued before the rows go in
    task automatic send_pair(input logic noisy_upper);
        pixel_t px [`POOL_SIZE][`POOL_ROW_WIDTH];
        word_t  w;
        for (int r = 0; r < `POOL_SIZE; r++) begin
            for (int c = 0; c < `POOL_ROW_WIDTH; c++) begin
                px[r][c] = pixel_t'($urandom);
            end
        end
        for (int k = 0; k < `POOL_OUT_WIDTH; k++) begin
            model_q.push_back(word_t'(max_of_block(px[0][2*k], px[0][2*k+1],
                                                   px[1][2*k], px[1][2*k+1])));
        end
        expected_total += `POOL_OUT_WIDTH;
        for (int r = 0; r < `POOL_SIZE; r++) begin
            for (int c = 0; c < `POOL_ROW_WIDTH; c++) begin
                w = noisy_upper ? word_t'($urandom) : '0;
                w[`POOL_VALUE_BITS-1:0] = px[r][c];
                send_word(w);
            end
        end
    endtask

    task automatic wait_outputs(input int target);
        int waited;
        waited = 0;
        while (out_words < target) begin
            @(posedge clock_i);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout in %s: only %0d of %0d output words arrived",
                         test_name, out_words, target);
                flow_errors++;
                finish_run();
            end
        end
    endtask

    // Waits until the input stays stalled, then lets the sink drain at random
    task automatic wait_input_blocked(input int start_count);
        int waited;
        int held;
        waited = 0;
        held   = 0;
        while (held < BLOCK_CYCLES) begin
            @(posedge clock_i);
            #1;
            waited++;
            held = upstream_stall_o ? held + 1 : 0;
            if (waited > WAIT_LIMIT) begin
                $display("timeout in %s: input never blocked with the sink stalled", test_name);
                flow_errors++;
                finish_run();
            end
        end
        assert (words_in - start_count == BLOCKED_WORDS) else begin
            $display("error %s: expected %0d, actual %0d", test_name, BLOCKED_WORDS,
                     words_in - start_count);
            flow_errors++;
        end
        stall_mode = 1;
    endtask

    task automatic check_drained();
        repeat (20) @(posedge clock_i);
        #1;
        assert (out_words == expected_total) else begin
            $display("error %s: expected %0d, actual %0d", test_name, expected_total, out_words);
            flow_errors++;
        end
    endtask

    initial begin
        int errors_before;
        int start_words;
        int start_out;
        void'($urandom(32'h84d9_df44));
        reset_i    = 1'b1;
        in_data_i  = '0;
        in_valid_i = 1'b0;

        test_name = "reset_quiet";
        errors_before = error_total();
        repeat (5) @(posedge clock_i);
        #1;
        reset_i = 1'b0;
        repeat (2) @(posedge clock_i);
        #1;
        report_test(errors_before);

        test_name = "pooling_value";
        errors_before = error_total();
        send_pair(1'b0);
        wait_outputs(expected_total);
        check_drained();
        report_test(errors_before);

        test_name = "upper_bits";
        errors_before = error_total();
        send_pair(1'b1);
        wait_outputs(expected_total);
        check_drained();
        report_test(errors_before);

        test_name = "stall_hold";
        errors_before = error_total();
        stall_mode = 1;
        send_pair(1'b1);
        send_pair(1'b0);
        wait_outputs(expected_total);
        stall_mode = 0;
        check_drained();
        report_test(errors_before);

        // Full image against a sink that starts fully stalled
        test_name = "backpressure";
        errors_before = error_total();
        start_words = words_in;
        start_out = out_words;
        stall_mode = 2;
        fork
            begin
                for (int p = 0; p < IMAGE_PAIRS; p++) begin
                    send_pair(1'b1);
                end
            end
            wait_input_blocked(start_words);
        join
        wait_outputs(expected_total);
        stall_mode = 0;
        check_drained();
        assert (out_words - start_out == IMAGE_PAIRS * `POOL_OUT_WIDTH) else begin
            $display("error %s: expected %0d, actual %0d", test_name,
                     IMAGE_PAIRS * `POOL_OUT_WIDTH, out_words - start_out);
            flow_errors++;
        end
        report_test(errors_before);

        finish_run();
    end

endmodule

`default_nettype wire

//--- hdl/max_pool_row.sv
// Max-pooling engine that folds each pair of input rows into one row of 2x2 block maxima
`default_nettype none
`include "pool_defines.svh"

module max_pool_row (
    input  wire logic              clock_i,
    input  wire logic              reset_i,
    input  wire pool_pkg::pixel_t  row_i [`POOL_ROW_WIDTH],
    input  wire logic              row_valid_i,
    output logic                   row_accept_o,
    output pool_pkg::pixel_t       pooled_row_o [`POOL_OUT_WIDTH],
    output logic                   pooled_valid_o,
    input  wire logic              pooled_accept_i
);
    import pool_pkg::*;

    localparam int COL_BITS = $clog2(`POOL_OUT_WIDTH);
    localparam int ROW_BITS = $clog2(`POOL_SIZE);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`POOL_OUT_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`POOL_SIZE - 1);

    pool_state_e         state_q;
    pool_state_e         state_d;
    // Output column being computed
    logic [COL_BITS-1:0] col_q;
    logic [COL_BITS-1:0] col_d;
    // Input rows already folded into the accumulator
    logic [ROW_BITS-1:0] row_cnt_q;
    logic [ROW_BITS-1:0] row_cnt_d;

    pixel_t              in_row_q [`POOL_ROW_WIDTH];
    pixel_t              acc_q [`POOL_OUT_WIDTH];

    logic                latch_row;
    logic                update_acc;
    logic                clear_acc;

    pixel_t              left_px;
    pixel_t              right_px;
    pixel_t              pair_max;
    pixel_t              col_max;

    // Horizontal pair under the current column, then fold in what the accumulator holds
    always_comb begin
        left_px  = in_row_q[{col_q, 1'b0}];
        right_px = in_row_q[{col_q, 1'b1}];
        pair_max = (left_px > right_px) ? left_px : right_px;
        col_max  = (acc_q[col_q] > pair_max) ? acc_q[col_q] : pair_max;
    end

    always_comb begin
        state_d        = state_q;
        col_d          = col_q;
        row_cnt_d      = row_cnt_q;
        latch_row      = 1'b0;
        update_acc     = 1'b0;
        clear_acc      = 1'b0;
        row_accept_o   = 1'b0;
        pooled_valid_o = 1'b0;

        case (state_q)
            POOL_GET_ROW: begin
                if (row_valid_i) begin
                    row_accept_o = 1'b1;
                    latch_row    = 1'b1;
                    col_d        = '0;
                    state_d      = POOL_COMPUTE_ROW;
                end
            end
            POOL_COMPUTE_ROW: begin
                // One output column per cycle
                update_acc = 1'b1;
                col_d      = col_q + 1'b1;
                if (col_q == LAST_COL) begin
                    col_d = '0;
                    if (row_cnt_q == LAST_ROW) begin
                        state_d = POOL_WAIT_READ;
                    end else begin
                        row_cnt_d = row_cnt_q + 1'b1;
                        state_d   = POOL_GET_ROW;
                    end
                end
            end
            POOL_WAIT_READ: begin
                pooled_valid_o = 1'b1;
                if (pooled_accept_i) begin
                    clear_acc = 1'b1;
                    row_cnt_d = '0;
                    state_d   = POOL_GET_ROW;
                end
            end
            default: begin
                state_d = POOL_GET_ROW;
            end
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q   <= POOL_GET_ROW;
            col_q     <= '0;
            row_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            col_q     <= col_d;
            row_cnt_q <= row_cnt_d;
        end
    end

    // Copy of the row being pooled, frees the deserializer to refill
    always_ff @(posedge clock_i) begin
        if (latch_row) begin
            in_row_q <= row_i;
        end
    end

    // Running maxima start from zero for every row pair
    always_ff @(posedge clock_i) begin
        if (reset_i || clear_acc) begin
            for (int i = 0; i < `POOL_OUT_WIDTH; i++) begin
                acc_q[i] <= '0;
            end
        end else if (update_acc) begin
            acc_q[col_q] <= col_max;
        end
    end

    assign pooled_row_o = acc_q;

endmodule

`default_nettype wire

//--- hdl/pool_defines.svh
// Sizes of the max-pooling stream stage, included by the package and every RTL file
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// Width of one grayscale pixel
`define POOL_VALUE_BITS 8

// Width of one stream word on the external ports
`define POOL_WORD_BITS 32

// Pixels in one input image row
`define POOL_ROW_WIDTH 28

// Edge of the square pooling window
`define POOL_SIZE 2

// Pixels in one pooled output row
`define POOL_OUT_WIDTH (`POOL_ROW_WIDTH / `POOL_SIZE)

`endif

//--- hdl/pool_pkg.sv
// Shared pixel, word and FSM state types, imported by the pooling RTL and its testbench
`default_nettype none
`include "pool_defines.svh"

package pool_pkg;

    // One unsigned grayscale value
    typedef logic [`POOL_VALUE_BITS-1:0] pixel_t;

    // One word on the input or output stream
    typedef logic [`POOL_WORD_BITS-1:0] word_t;

    // Pooling engine control
    typedef enum logic [1:0] {
        POOL_GET_ROW,
        POOL_COMPUTE_ROW,
        POOL_WAIT_READ
    } pool_state_e;

    // Output serializer control
    typedef enum logic [0:0] {
        SER_IDLE,
        SER_SEND
    } ser_state_e;

endpackage

`default_nettype wire

//--- hdl/pool_top.sv
// Top level of the 2x2 max-pooling stream stage with word-wide valid/stall ports on both sides
`default_nettype none
`include "pool_defines.svh"

module pool_top (
    input  wire logic             clock_i,
    input  wire logic             reset_i,
    // Source side
    input  wire pool_pkg::word_t  in_data_i,
    input  wire logic             in_valid_i,
    output logic                  upstream_stall_o,
    // Sink side
    output pool_pkg::word_t       out_data_o,
    output logic                  out_valid_o,
    input  wire logic             downstream_stall_i
);
    import pool_pkg::*;

    // Full input row from the deserializer
    pixel_t in_row [`POOL_ROW_WIDTH];
    logic   in_row_valid;
    logic   in_row_accept;

    // Pooled row from the engine
    pixel_t pooled_row [`POOL_OUT_WIDTH];
    logic   pooled_valid;
    logic   pooled_accept;

    row_deserializer u_deser (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .upstream_stall_o (upstream_stall_o),
        .row_o            (in_row),
        .row_valid_o      (in_row_valid),
        .row_accept_i     (in_row_accept)
    );

    max_pool_row u_pool (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .row_i           (in_row),
        .row_valid_i     (in_row_valid),
        .row_accept_o    (in_row_accept),
        .pooled_row_o    (pooled_row),
        .pooled_valid_o  (pooled_valid),
        .pooled_accept_i (pooled_accept)
    );

    // Stall from the sink backs up through the serializer into the engine
    row_serializer u_ser (
        .clock_i            (clock_i),
        .reset_i            (reset_i),
        .row_i              (pooled_row),
        .row_valid_i        (pooled_valid),
        .row_accept_o       (pooled_accept),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

endmodule

`default_nettype wire

//--- hdl/row_deserializer.sv
// Input parallelizer that packs one pixel per accepted word into a row for the pooling engine
`default_nettype none
`include "pool_defines.svh"

module row_deserializer (
    input  wire logic              clock_i,
    input  wire logic              reset_i,
    input  wire pool_pkg::word_t   in_data_i,
    input  wire logic              in_valid_i,
    output logic                   upstream_stall_o,
    output pool_pkg::pixel_t       row_o [`POOL_ROW_WIDTH],
    output logic                   row_valid_o,
    input  wire logic              row_accept_i
);
    import pool_pkg::*;

    localparam int COL_BITS = $clog2(`POOL_ROW_WIDTH);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`POOL_ROW_WIDTH - 1);

    // Column where the next pixel lands
    logic [COL_BITS-1:0] col_q;
    // Set once the row holds all its pixels
    logic                full_q;
    pixel_t              row_q [`POOL_ROW_WIDTH];

    logic                take_word;

    // Words are only taken while the row still has room
    assign take_word = in_valid_i && !full_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            col_q  <= '0;
            full_q <= 1'b0;
        end else if (full_q) begin
            if (row_accept_i) begin
                full_q <= 1'b0;
                col_q  <= '0;
            end
        end else if (take_word) begin
            if (col_q == LAST_COL) begin
                full_q <= 1'b1;
                col_q  <= '0;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Pixel storage, upper bits of the word are dropped
    always_ff @(posedge clock_i) begin
        if (take_word) begin
            row_q[col_q] <= in_data_i[`POOL_VALUE_BITS-1:0];
        end
    end

    assign row_o            = row_q;
    assign row_valid_o      = full_q;
    assign upstream_stall_o = full_q;

endmodule

`default_nettype wire

//--- hdl/row_serializer.sv
// Output serializer that streams a pooled row as zero-extended words under downstream stall
`default_nettype none
`include "pool_defines.svh"

module row_serializer (
    input  wire logic              clock_i,
    input  wire logic              reset_i,
    input  wire pool_pkg::pixel_t  row_i [`POOL_OUT_WIDTH],
    input  wire logic              row_valid_i,
    output logic                   row_accept_o,
    output pool_pkg::word_t        out_data_o,
    output logic                   out_valid_o,
    input  wire logic              downstream_stall_i
);
    import pool_pkg::*;

    localparam int IDX_BITS = $clog2(`POOL_OUT_WIDTH);
    localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(`POOL_OUT_WIDTH - 1);

    ser_state_e          state_q;
    // Word currently presented on the output
    logic [IDX_BITS-1:0] idx_q;
    pixel_t              hold_q [`POOL_OUT_WIDTH];

    // A new row is only taken once the previous one is fully sent
    assign row_accept_o = (state_q == SER_IDLE) && row_valid_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= SER_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (row_accept_o) begin
                        idx_q   <= '0;
                        state_q <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    if (!downstream_stall_i) begin
                        if (idx_q == LAST_IDX) begin
                            state_q <= SER_IDLE;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (row_accept_o) begin
            hold_q <= row_i;
        end
    end

    // Data stays put while stalled since idx_q only moves on a transfer
    assign out_data_o  = {{(`POOL_WORD_BITS - `POOL_VALUE_BITS){1'b0}}, hold_q[idx_q]};
    assign out_valid_o = (state_q == SER_SEND);

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/pool_pkg.sv
hdl/row_deserializer.sv
hdl/max_pool_row.sv
hdl/row_serializer.sv
hdl/pool_top.sv
dv/pool_tb.sv
